// ==== design/gat_pkg.sv ====
package gat_pkg;

  // ====================
  // Widths
  // ====================

  // Features per vector
  parameter int NUM_FEATURE_OUT = 4;

  // Signed Wh feature
  parameter int WH_DATA_WIDTH = 8;

  // Unsigned alpha in Q0.8
  parameter int ALPHA_WIDTH = 8;
  parameter int ALPHA_FRAC = 8;

  // Unsigned output feature
  parameter int DATA_WIDTH = 8;

  // Group length field, up to 15 neighbours
  parameter int NUM_NODE_WIDTH = 4;

  // Full-precision product and group sum
  parameter int PROD_WIDTH = WH_DATA_WIDTH + ALPHA_WIDTH;
  parameter int ACC_WIDTH = PROD_WIDTH + NUM_NODE_WIDTH;

  // ====================
  // Packed types
  // ====================

  // One Wh memory word
  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] feat;
    logic [NUM_NODE_WIDTH-1:0]                     num_node;
    logic                                          src_flag;
  } wh_entry_t;

  // Group position of a product beat
  typedef struct packed {
    logic first;
    logic last;
  } mul_tag_t;

  typedef logic [NUM_FEATURE_OUT-1:0][ACC_WIDTH-1:0] acc_vec_t;

  typedef logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] feat_vec_t;

endpackage

// ==== design/sync_fifo.sv ====
module sync_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push,
  input  logic [gat_pkg::ALPHA_WIDTH-1:0] din,
  input  logic                            pop,
  output logic [gat_pkg::ALPHA_WIDTH-1:0] dout,
  output logic                            full,
  output logic                            empty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [gat_pkg::ALPHA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]                wr_ptr;
  logic [PTR_W-1:0]                rd_ptr;
  logic [CNT_W-1:0]                count;
  logic                            do_push;
  logic                            do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Head entry is always visible on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap at FIFO_DEPTH even for non power-of-two depths
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== design/wh_bram.sv ====
module wh_bram #(
  parameter int WH_DEPTH = 64
) (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [$clog2(WH_DEPTH)-1:0] wr_addr,
  input  gat_pkg::wh_entry_t         wr_data,
  input  logic [$clog2(WH_DEPTH)-1:0] rd_addr,
  output gat_pkg::wh_entry_t         rd_data
);

  localparam int WH_ADDR_W = $clog2(WH_DEPTH);

  gat_pkg::wh_entry_t mem [WH_DEPTH];

  // Write port, loaded from the top level
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr[WH_ADDR_W-1:0]];
  end

endmodule

// ==== design/fxp_mul_pipe.sv ====
module fxp_mul_pipe (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_vld,
  input  logic signed [gat_pkg::WH_DATA_WIDTH-1:0] ina,
  input  logic [gat_pkg::ALPHA_WIDTH-1:0]        inb,
  output logic                                   out_vld,
  output logic signed [gat_pkg::PROD_WIDTH-1:0]  out
);

  logic                                   vld_q;
  logic signed [gat_pkg::WH_DATA_WIDTH-1:0] a_q;
  logic [gat_pkg::ALPHA_WIDTH-1:0]        b_q;
  logic signed [gat_pkg::ALPHA_WIDTH:0]   b_ext;

  // Alpha is unsigned, so widen with a zero sign bit
  assign b_ext = $signed({1'b0, b_q});

  // ====================
  // Valid pipe
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q   <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      vld_q   <= in_vld;
      out_vld <= vld_q;
    end
  end

  // ====================
  // Data pipe
  // ====================

  // Stage 1 captures the operands
  always_ff @(posedge clk) begin
    a_q <= ina;
    b_q <= inb;
  end

  // Stage 2 holds the full-precision product
  // 8b signed x 9b signed fits in 16 bits for these ranges
  always_ff @(posedge clk) begin
    out <= a_q * b_ext;
  end

endmodule

// ==== design/feature_controller.sv ====
module feature_controller #(
  parameter int FEAT_ADDR_W = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clear,
  input  logic                   acc_vld,
  input  gat_pkg::acc_vec_t      acc,
  output logic                   feat_wr_en,
  output logic [FEAT_ADDR_W-1:0] feat_wr_addr,
  output gat_pkg::feat_vec_t     feat_wr_data
);

  localparam int AW = gat_pkg::ACC_WIDTH;
  localparam int DW = gat_pkg::DATA_WIDTH;

  gat_pkg::feat_vec_t feat_sat;

  // ====================
  // Scale and clamp
  // ====================

  // Floor shift back to integer scale, then ReLU and saturate
  always_comb begin
    logic signed [AW-1:0] shifted;
    shifted = '0;
    for (int k = 0; k < gat_pkg::NUM_FEATURE_OUT; k++) begin
      shifted = $signed(acc[k]) >>> gat_pkg::ALPHA_FRAC;
      if (shifted[AW-1]) begin
        feat_sat[k] = '0;
      end else if (|shifted[AW-2:DW]) begin
        feat_sat[k] = '1;
      end else begin
        feat_sat[k] = shifted[DW-1:0];
      end
    end
  end

  // ====================
  // Write port
  // ====================

  // Address moves on after each write so results land back to back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_wr_en   <= 1'b0;
      feat_wr_addr <= '0;
    end else begin
      feat_wr_en <= acc_vld;
      if (clear) begin
        feat_wr_addr <= '0;
      end else if (feat_wr_en) begin
        feat_wr_addr <= feat_wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_vld) begin
      feat_wr_data <= feat_sat;
    end
  end

endmodule

// ==== design/aggregator.sv ====
module aggregator #(
  parameter int WH_DEPTH    = 64,
  parameter int FEAT_ADDR_W = 6
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear,
  input  logic [gat_pkg::ALPHA_WIDTH-1:0] alpha_dout,
  input  logic                            alpha_empty,
  output logic                            alpha_pop,
  output logic [$clog2(WH_DEPTH)-1:0]     wh_rd_addr,
  input  gat_pkg::wh_entry_t              wh_rd_data,
  output logic                            feat_wr_en,
  output logic [FEAT_ADDR_W-1:0]          feat_wr_addr,
  output gat_pkg::feat_vec_t              feat_wr_data
);

  localparam int WH_ADDR_W = $clog2(WH_DEPTH);
  localparam int NF        = gat_pkg::NUM_FEATURE_OUT;
  localparam int EXT_W     = gat_pkg::ACC_WIDTH - gat_pkg::PROD_WIDTH;

  logic [WH_ADDR_W-1:0]                  wh_addr_q;
  logic [gat_pkg::ALPHA_WIDTH-1:0]       alpha_q;
  logic                                  beat_vld;
  logic [gat_pkg::NUM_NODE_WIDTH-1:0]    remain_q;
  logic [gat_pkg::NUM_NODE_WIDTH-1:0]    remain_cur;
  gat_pkg::mul_tag_t                     tag;
  gat_pkg::mul_tag_t                     tag_d1;
  gat_pkg::mul_tag_t                     tag_d2;
  logic [NF-1:0]                         mul_vld;
  logic signed [gat_pkg::PROD_WIDTH-1:0] prod [NF];
  logic [NF-1:0][gat_pkg::ACC_WIDTH-1:0] prod_ext;
  gat_pkg::acc_vec_t                     acc_q;
  gat_pkg::acc_vec_t                     acc_next;
  logic                                  acc_vld;

  // ====================
  // Fetch stage
  // ====================

  // No back-pressure, so every available alpha is taken at once
  assign alpha_pop  = !alpha_empty;
  assign wh_rd_addr = wh_addr_q;

  // A group header reloads the neighbour count
  assign remain_cur = wh_rd_data.src_flag ? wh_rd_data.num_node : remain_q;
  assign tag.first  = wh_rd_data.src_flag;
  assign tag.last   = (remain_cur == gat_pkg::NUM_NODE_WIDTH'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_addr_q <= '0;
      beat_vld  <= 1'b0;
      remain_q  <= '0;
      tag_d1    <= '0;
      tag_d2    <= '0;
    end else if (clear) begin
      wh_addr_q <= '0;
      beat_vld  <= 1'b0;
      remain_q  <= '0;
      tag_d1    <= '0;
      tag_d2    <= '0;
    end else begin
      if (alpha_pop) begin
        wh_addr_q <= wh_addr_q + 1'b1;
      end
      beat_vld <= alpha_pop;
      if (beat_vld) begin
        remain_q <= remain_cur - 1'b1;
      end
      // Tag follows the two multiplier stages
      tag_d1 <= tag;
      tag_d2 <= tag_d1;
    end
  end

  // Alpha lines up with the registered Wh read data
  always_ff @(posedge clk) begin
    alpha_q <= alpha_dout;
  end

  // ====================
  // Multiply stage
  // ====================
  for (genvar i = 0; i < NF; i++) begin : g_mul
    fxp_mul_pipe u_mul (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_vld  (beat_vld),
      .ina     ($signed(wh_rd_data.feat[i])),
      .inb     (alpha_q),
      .out_vld (mul_vld[i]),
      .out     (prod[i])
    );

    assign prod_ext[i] = {{EXT_W{prod[i][gat_pkg::PROD_WIDTH-1]}}, prod[i]};
  end

  // ====================
  // Accumulate stage
  // ====================

  // A first product restarts the sum, anything else adds to it
  always_comb begin
    for (int k = 0; k < NF; k++) begin
      if (tag_d2.first) begin
        acc_next[k] = prod_ext[k];
      end else begin
        acc_next[k] = acc_q[k] + prod_ext[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (&mul_vld) begin
      acc_q <= acc_next;
    end
  end

  // Finished group goes out in the same cycle as its last product
  assign acc_vld = (&mul_vld) && tag_d2.last;

  feature_controller #(
    .FEAT_ADDR_W (FEAT_ADDR_W)
  ) u_feature_controller (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .acc_vld      (acc_vld),
    .acc          (acc_next),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data)
  );

endmodule

// ==== design/aggr_top.sv ====
module aggr_top #(
  parameter int WH_DEPTH    = 64,
  parameter int FIFO_DEPTH  = 16,
  parameter int FEAT_ADDR_W = 6
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear,
  input  logic                            wh_wr_en,
  input  logic [$clog2(WH_DEPTH)-1:0]     wh_wr_addr,
  input  gat_pkg::wh_entry_t              wh_wr_data,
  input  logic                            alpha_push,
  input  logic [gat_pkg::ALPHA_WIDTH-1:0] alpha_data,
  output logic                            alpha_full,
  output logic                            feat_wr_en,
  output logic [FEAT_ADDR_W-1:0]          feat_wr_addr,
  output gat_pkg::feat_vec_t              feat_wr_data
);

  localparam int WH_ADDR_W = $clog2(WH_DEPTH);

  logic                            alpha_empty;
  logic                            alpha_pop;
  logic [gat_pkg::ALPHA_WIDTH-1:0] alpha_dout;
  logic [WH_ADDR_W-1:0]            wh_rd_addr;
  gat_pkg::wh_entry_t              wh_rd_data;

  // Alpha coefficients from the softmax side
  sync_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (alpha_push),
    .din   (alpha_data),
    .pop   (alpha_pop),
    .dout  (alpha_dout),
    .full  (alpha_full),
    .empty (alpha_empty)
  );

  // Projected neighbour vectors
  wh_bram #(
    .WH_DEPTH (WH_DEPTH)
  ) u_wh_bram (
    .clk     (clk),
    .wr_en   (wh_wr_en),
    .wr_addr (wh_wr_addr),
    .wr_data (wh_wr_data),
    .rd_addr (wh_rd_addr),
    .rd_data (wh_rd_data)
  );

  aggregator #(
    .WH_DEPTH    (WH_DEPTH),
    .FEAT_ADDR_W (FEAT_ADDR_W)
  ) u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .alpha_dout   (alpha_dout),
    .alpha_empty  (alpha_empty),
    .alpha_pop    (alpha_pop),
    .wh_rd_addr   (wh_rd_addr),
    .wh_rd_data   (wh_rd_data),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data)
  );

endmodule

// ==== sim/aggr_properties.sv ====
module aggr_properties #(
  parameter int FEAT_ADDR_W = 6
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   clear,
  input logic                   alpha_push,
  input logic                   alpha_full,
  input logic                   feat_wr_en,
  input logic [FEAT_ADDR_W-1:0] feat_wr_addr
);

  logic                   seen_write;
  logic                   clear_since;
  logic [FEAT_ADDR_W-1:0] last_addr;

  // Remembers the previous write address and any clear after it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_write  <= 1'b0;
      clear_since <= 1'b0;
      last_addr   <= '0;
    end else begin
      if (feat_wr_en) begin
        seen_write  <= 1'b1;
        last_addr   <= feat_wr_addr;
        clear_since <= clear;
      end else if (clear) begin
        clear_since <= 1'b1;
      end
    end
  end

  // ====================
  // Rules
  // ====================
  no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) alpha_full |-> !alpha_push
  ) else $error("alpha pushed while the FIFO is full");

  addr_steps_by_one: assert property (
    @(posedge clk) disable iff (!rst_n)
    (feat_wr_en && seen_write && !clear_since) |->
      (feat_wr_addr == FEAT_ADDR_W'(last_addr + 1'b1))
  ) else $error("feature write address did not advance by one");

  no_write_in_reset: assert property (
    @(posedge clk) !rst_n |-> !feat_wr_en
  ) else $error("feature write enable high during reset");

endmodule

bind aggr_top aggr_properties #(
  .FEAT_ADDR_W (FEAT_ADDR_W)
) u_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .clear        (clear),
  .alpha_push   (alpha_push),
  .alpha_full   (alpha_full),
  .feat_wr_en   (feat_wr_en),
  .feat_wr_addr (feat_wr_addr)
);

// ==== sim/aggr_tb.sv ====
module aggr_tb;

  localparam int NF          = gat_pkg::NUM_FEATURE_OUT;
  localparam int WH_DEPTH    = 64;
  localparam int WH_ADDR_W   = $clog2(WH_DEPTH);
  localparam int FIFO_DEPTH  = 16;
  localparam int FEAT_ADDR_W = 6;
  localparam int CLK_PERIOD  = 10;
  localparam int NUM_TESTS   = 5;
  localparam int MAX_GROUPS  = 5;
  localparam int MAX_BEATS   = 64;
  localparam int FEAT_MAX    = (1 << gat_pkg::DATA_WIDTH) - 1;

  logic                            clk;
  logic                            rst_n;
  logic                            clear;
  logic                            wh_wr_en;
  logic [WH_ADDR_W-1:0]            wh_wr_addr;
  gat_pkg::wh_entry_t              wh_wr_data;
  logic                            alpha_push;
  logic [gat_pkg::ALPHA_WIDTH-1:0] alpha_data;
  logic                            alpha_full;
  logic                            feat_wr_en;
  logic [FEAT_ADDR_W-1:0]          feat_wr_addr;
  gat_pkg::feat_vec_t              feat_wr_data;

  // ====================
  // Test table
  // ====================

  // Data mode 0 fixed vector, 1 random, 2 ReLU and clamp corners; group lengths end at 0
  string test_name [NUM_TESTS] = '{"single_max_alpha", "mixed_groups", "relu_and_clamp",
                                   "random_gaps", "clear_restart"};
  int    data_mode [NUM_TESTS] = '{0, 1, 2, 1, 1};
  bit    use_gaps  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  int    grp_len   [NUM_TESTS][MAX_GROUPS] = '{'{1, 0, 0, 0, 0}, '{1, 3, 15, 2, 7},
                                               '{2, 4, 3, 0, 0}, '{1, 3, 15, 2, 7},
                                               '{4, 1, 2, 0, 0}};
  int    single_vec [NF] = '{100, -50, 1, 127};

  int                 wh_val [MAX_BEATS][NF];
  int                 alpha_val [MAX_BEATS];
  bit                 first_beat [MAX_BEATS];
  int                 beat_glen [MAX_BEATS];
  int                 n_beats;
  gat_pkg::feat_vec_t exp_q [$];
  gat_pkg::feat_vec_t got_data_q [$];
  int                 got_addr_q [$];
  int                 data_seed;
  int                 gap_seed;
  int                 cycle_cnt = 0;
  int                 last_pop_cycle = 0;
  int                 first_wr_cycle = 0;
  int                 errors = 0;
  int                 test_errors = 0;

  aggr_top #(
    .WH_DEPTH    (WH_DEPTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FEAT_ADDR_W (FEAT_ADDR_W)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .wh_wr_en     (wh_wr_en),
    .wh_wr_addr   (wh_wr_addr),
    .wh_wr_data   (wh_wr_data),
    .alpha_push   (alpha_push),
    .alpha_data   (alpha_data),
    .alpha_full   (alpha_full),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Capture every feature write, and the cycle of the latest pop
  always @(posedge clk) begin
    if (rst_n && feat_wr_en) begin
      if (got_data_q.size() == 0) begin
        first_wr_cycle = cycle_cnt;
      end
      got_addr_q.push_back(int'(feat_wr_addr));
      got_data_q.push_back(feat_wr_data);
    end
    if (rst_n && u_dut.alpha_pop) begin
      last_pop_cycle = cycle_cnt;
    end
    cycle_cnt++;
  end

  task automatic check_value(input string what, input longint expected, input longint actual);
    if (expected !== actual) begin
      $display("** Error: %s: expected %0h, actual %0h", what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  // ====================
  // Stimulus and reference
  // ====================
  task automatic build_stimulus(input int t);
    int b;
    b = 0;
    data_seed = 4;
    for (int g = 0; g < MAX_GROUPS && grp_len[t][g] != 0; g++) begin
      for (int k = 0; k < grp_len[t][g]; k++) begin
        first_beat[b] = (k == 0);
        beat_glen[b]  = (k == 0) ? grp_len[t][g] : 0;
        for (int f = 0; f < NF; f++) begin
          case (data_mode[t])
            0:       wh_val[b][f] = single_vec[f];
            1:       wh_val[b][f] = $random(data_seed) % 128;
            default: wh_val[b][f] = (g == 0) ? -(90 + 10 * k + f) :
                                    (g == 1) ? 127 : ((f % 2 == 0) ? 120 : -120);
          endcase
        end
        case (data_mode[t])
          0:       alpha_val[b] = 255;
          1:       alpha_val[b] = $random(data_seed) & 255;
          default: alpha_val[b] = (g == 0) ? 200 : ((g == 1) ? 255 : 230);
        endcase
        b++;
      end
    end
    n_beats = b;
  endtask

  // Weighted sum per group, floor shift back to integer, then ReLU and clamp
  task automatic build_expected();
    int                 sum [NF];
    int                 q;
    gat_pkg::feat_vec_t v;
    exp_q.delete();
    for (int b = 0; b < n_beats; b++) begin
      for (int f = 0; f < NF; f++) begin
        if (first_beat[b]) begin
          sum[f] = 0;
        end
        sum[f] += wh_val[b][f] * alpha_val[b];
      end
      if (b == n_beats - 1 || first_beat[b + 1]) begin
        for (int f = 0; f < NF; f++) begin
          q    = sum[f] >>> gat_pkg::ALPHA_FRAC;
          v[f] = (q < 0) ? 0 : ((q > FEAT_MAX) ? FEAT_MAX : q);
        end
        exp_q.push_back(v);
      end
    end
  endtask

  task automatic load_wh();
    for (int b = 0; b < n_beats; b++) begin
      @(negedge clk);
      wh_wr_en            = 1'b1;
      wh_wr_addr          = WH_ADDR_W'(b);
      wh_wr_data.src_flag = first_beat[b];
      wh_wr_data.num_node = gat_pkg::NUM_NODE_WIDTH'(beat_glen[b]);
      for (int f = 0; f < NF; f++) begin
        wh_wr_data.feat[f] = gat_pkg::WH_DATA_WIDTH'(wh_val[b][f]);
      end
    end
    @(negedge clk);
    wh_wr_en = 1'b0;
  endtask

  task automatic push_alphas(input string name, input bit gaps);
    int pause;
    for (int b = 0; b < n_beats; b++) begin
      if (gaps) begin
        pause      = $unsigned($random(gap_seed)) % 4;
        alpha_push = 1'b0;
        repeat (pause) @(negedge clk);
      end
      // Pops keep pace with single pushes so the FIFO never fills
      check_value({name, " alpha_full"}, 0, alpha_full);
      while (alpha_full) begin
        alpha_push = 1'b0;
        @(negedge clk);
      end
      alpha_push = 1'b1;
      alpha_data = gat_pkg::ALPHA_WIDTH'(alpha_val[b]);
      @(negedge clk);
    end
    alpha_push = 1'b0;
  endtask

  // Limit scales with the number of pushes in the whole table
  initial begin
    int limit;
    limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int g = 0; g < MAX_GROUPS; g++) begin
        limit += grp_len[t][g];
      end
    end
    limit = (5 * limit + 80 * NUM_TESTS) * CLK_PERIOD;
    #(limit);
    $display("Watchdog: run did not finish within %0d time units", limit);
    $display("=== FAIL ===");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    int wait_cycles;
    int tests_failed;
    rst_n        = 1'b0;
    clear        = 1'b0;
    wh_wr_en     = 1'b0;
    wh_wr_addr   = '0;
    wh_wr_data   = '0;
    alpha_push   = 1'b0;
    alpha_data   = '0;
    gap_seed     = 4;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors = 0;
      build_stimulus(t);
      build_expected();
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      got_addr_q.delete();
      got_data_q.delete();
      load_wh();
      push_alphas(test_name[t], use_gaps[t]);
      wait_cycles = 0;
      while (got_data_q.size() < exp_q.size() && wait_cycles < 50) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (got_data_q.size() < exp_q.size()) begin
        $display("Test %s timed out waiting for feature writes", test_name[t]);
      end
      // Room for any stray extra write
      repeat (6) @(negedge clk);
      check_value({test_name[t], " write count"}, exp_q.size(), got_data_q.size());
      for (int i = 0; i < exp_q.size() && i < got_data_q.size(); i++) begin
        check_value($sformatf("%s write %0d address", test_name[t], i), i, got_addr_q[i]);
        check_value($sformatf("%s write %0d data", test_name[t], i), exp_q[i], got_data_q[i]);
      end
      if (t == 0) begin
        check_value({test_name[t], " latency"}, 4, first_wr_cycle - last_pop_cycle);
      end
      if (test_errors != 0) begin
        tests_failed++;
      end
      $display("Test %s: %0d writes, %s", test_name[t], got_data_q.size(),
               (test_errors == 0) ? "passed" : "failed");
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/gat_pkg.sv
design/sync_fifo.sv
design/wh_bram.sv
design/fxp_mul_pipe.sv
design/feature_controller.sv
design/aggregator.sv
design/aggr_top.sv
sim/aggr_properties.sv
sim/aggr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module aggr_tb -f flist.f

# A failing simulation still reaches the search below
sim_out=$(./obj_dir/Vaggr_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "=== PASS ==="; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
